// File: rtl/core_cfg_pkg.sv
// core settings definitions
// bridge widths, setting addresses, the settings struct and its reset value
// pad count, key width and the console pad word

package core_cfg_pkg;

    localparam int BRIDGE_W  = 32;
    localparam int PAD_COUNT = 4;
    localparam int KEY_W     = 16;

    // one word per setting on the bridge
    typedef enum logic [BRIDGE_W-1:0] {
        CFG_MULTITAP     = 32'h0000_0000,
        CFG_AR_CORRECT   = 32'h0000_0010,
        CFG_COMPOSITE    = 32'h0000_0020,
        CFG_OBJ_LIMIT    = 32'h0000_0030,
        CFG_FM           = 32'h0000_0040,
        CFG_PSG          = 32'h0000_0050,
        CFG_HIFI_PCM     = 32'h0000_0060,
        CFG_M30_PAD1     = 32'h0000_0080,
        CFG_M30_PAD2     = 32'h0000_0090,
        CFG_M30_PAD3     = 32'h0000_0100,
        CFG_M30_PAD4     = 32'h0000_0110,
        CFG_FM_CHIP      = 32'h00A0_0000,
        CFG_TURBO        = 32'h00C0_0000,
        CFG_AUDIO_FILTER = 32'h00F0_0000
    } cfg_addr_e;

    localparam logic [BRIDGE_W-1:0] REGION_RD_ADDR = 32'h00E0_0000;

    typedef struct packed {
        logic [1:0] cpu_turbo;
        logic [1:0] audio_filter;
        logic       fm_chip;
        logic       multitap;
        logic       ar_correct;
        logic       composite;
        logic       obj_limit_high;
        logic       fm_en;
        logic       psg_en;
        logic       hifi_pcm;
        logic [3:0] m30_map;          // one bit per pad, pad 1 in bit 0
    } core_cfg_t;

    localparam core_cfg_t CFG_RESET = '{
        obj_limit_high: 1'b1,
        fm_en:          1'b1,
        psg_en:         1'b1,
        hifi_pcm:       1'b1,
        default:        '0
    };

    typedef logic [11:0] pad_word_t;  // Z Y X mode start B C A up down left right

endpackage

// File: rtl/cart_pkg.sv
// cartridge header definitions
// ROM stream widths, header offsets and the region enum
// quirk struct and the per-title quirk table

package cart_pkg;

    localparam int ROM_ADDR_W = 25;
    localparam int ROM_DATA_W = 16;

    // byte offsets into the header
    localparam logic [ROM_ADDR_W-1:0] HDR_REGION0 = 25'h1F0;
    localparam logic [ROM_ADDR_W-1:0] HDR_REGION1 = 25'h1F2;
    localparam logic [ROM_ADDR_W-1:0] HDR_END     = 25'h200;
    localparam logic [ROM_ADDR_W-1:0] HDR_ID0     = 25'h182;
    localparam logic [ROM_ADDR_W-1:0] HDR_ID1     = 25'h184;
    localparam logic [ROM_ADDR_W-1:0] HDR_ID2     = 25'h186;
    localparam logic [ROM_ADDR_W-1:0] HDR_ID3     = 25'h188;
    localparam logic [ROM_ADDR_W-1:0] HDR_ID4     = 25'h18A;
    localparam logic [ROM_ADDR_W-1:0] HDR_ID_DONE = 25'h18C;

    typedef enum logic [1:0] {
        REGION_JP = 2'd0,
        REGION_US = 2'd1,
        REGION_EU = 2'd2
    } region_e;

    typedef logic [63:0] cart_id_t;   // eight ascii chars, first in the top byte

    typedef struct packed {
        logic       sram;
        logic       sram00;
        logic       eeprom;
        logic       fifo;
        logic       noram;
        logic       pier;
        logic       svp;
        logic       fmbusy;
        logic       schan;
        logic       gun_type;
        logic [7:0] gun_delay;        // lightgun sensor offset
    } quirk_t;

    localparam logic [7:0] GUN_DELAY_DEFAULT = 8'd44;
    localparam quirk_t QUIRK_NONE = '{gun_delay: GUN_DELAY_DEFAULT, default: '0};

    typedef struct packed {
        cart_id_t id;
        quirk_t   quirk;
    } title_t;

    localparam int TITLE_COUNT = 8;

    localparam title_t TITLES [TITLE_COUNT] = '{
        '{id: "T-081276", quirk: '{sram:   1'b1, gun_delay: GUN_DELAY_DEFAULT, default: '0}},
        '{id: "MK-1215 ", quirk: '{eeprom: 1'b1, gun_delay: GUN_DELAY_DEFAULT, default: '0}},
        '{id: "T-113016", quirk: '{noram:  1'b1, gun_delay: GUN_DELAY_DEFAULT, default: '0}},
        '{id: "T-89016 ", quirk: '{fifo:   1'b1, gun_delay: GUN_DELAY_DEFAULT, default: '0}},
        '{id: "T-574023", quirk: '{pier:   1'b1, gun_delay: GUN_DELAY_DEFAULT, default: '0}},
        '{id: "MK-1229 ", quirk: '{svp:    1'b1, gun_delay: GUN_DELAY_DEFAULT, default: '0}},
        '{id: "T-35036 ", quirk: '{fmbusy: 1'b1, gun_delay: GUN_DELAY_DEFAULT, default: '0}},
        '{id: "T-95096-", quirk: '{gun_type: 1'b1, gun_delay: 8'd52, default: '0}}
    };

endpackage

// File: rtl/rom_write_if.sv
// ROM download word stream
// source and sink modports

`timescale 1ns/1ps

interface rom_write_if;

    logic                          download;  // high for the whole transfer
    logic                          wr;        // one strobe per word
    logic [cart_pkg::ROM_ADDR_W-1:0] addr;    // byte address
    logic [cart_pkg::ROM_DATA_W-1:0] data;    // low byte first in header text

    modport source (output download, wr, addr, data);
    modport sink   (input  download, wr, addr, data);

endinterface

// File: rtl/core_settings.sv
// settings register bank written over the bridge
// bridge read mux for the region readback

`timescale 1ns/1ps

module core_settings (
    input  logic                               clk_74a,
    input  logic                               pll_core_locked,
    input  logic [core_cfg_pkg::BRIDGE_W-1:0]  bridge_addr,
    input  logic                               bridge_wr,
    input  logic [core_cfg_pkg::BRIDGE_W-1:0]  bridge_wr_data,
    input  cart_pkg::region_e                  region,
    output logic [core_cfg_pkg::BRIDGE_W-1:0]  bridge_rd_data,
    output core_cfg_pkg::core_cfg_t            core_cfg
);

    ////////////////////////////////////////////////////////////
    // write decode

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            core_cfg <= core_cfg_pkg::CFG_RESET;
        end else if (bridge_wr) begin
            case (bridge_addr)
                core_cfg_pkg::CFG_TURBO:        core_cfg.cpu_turbo      <= bridge_wr_data[1:0];
                core_cfg_pkg::CFG_AUDIO_FILTER: core_cfg.audio_filter   <= bridge_wr_data[1:0];
                core_cfg_pkg::CFG_FM_CHIP:      core_cfg.fm_chip        <= bridge_wr_data[0];
                core_cfg_pkg::CFG_MULTITAP:     core_cfg.multitap       <= bridge_wr_data[0];
                core_cfg_pkg::CFG_AR_CORRECT:   core_cfg.ar_correct     <= bridge_wr_data[0];
                core_cfg_pkg::CFG_COMPOSITE:    core_cfg.composite      <= bridge_wr_data[0];
                core_cfg_pkg::CFG_OBJ_LIMIT:    core_cfg.obj_limit_high <= bridge_wr_data[0];
                core_cfg_pkg::CFG_FM:           core_cfg.fm_en          <= bridge_wr_data[0];
                core_cfg_pkg::CFG_PSG:          core_cfg.psg_en         <= bridge_wr_data[0];
                core_cfg_pkg::CFG_HIFI_PCM:     core_cfg.hifi_pcm       <= bridge_wr_data[0];
                core_cfg_pkg::CFG_M30_PAD1:     core_cfg.m30_map[0]     <= bridge_wr_data[0];
                core_cfg_pkg::CFG_M30_PAD2:     core_cfg.m30_map[1]     <= bridge_wr_data[0];
                core_cfg_pkg::CFG_M30_PAD3:     core_cfg.m30_map[2]     <= bridge_wr_data[0];
                core_cfg_pkg::CFG_M30_PAD4:     core_cfg.m30_map[3]     <= bridge_wr_data[0];
                default: ;  // unlisted address, bank unchanged
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // read mux

    always_comb begin
        bridge_rd_data = '0;
        if (bridge_addr == core_cfg_pkg::REGION_RD_ADDR) begin
            bridge_rd_data = {{(core_cfg_pkg::BRIDGE_W-2){1'b0}}, region};
        end
    end

    // host must not strobe a write with floating data
    a_wr_data_known: assert property (
        @(posedge clk_74a) disable iff (!pll_core_locked)
        bridge_wr |-> !$isunknown(bridge_wr_data)
    );

endmodule

// File: rtl/cart_region_detect.sv
// header region parsing during ROM download
// region request on header ready and core reset hold

`timescale 1ns/1ps

module cart_region_detect (
    input  logic              clk_74a,
    input  logic              pll_core_locked,
    rom_write_if.sink         rom,
    output cart_pkg::region_e region,
    output logic              core_reset_n
);

    logic [2:0] flags;       // {e, u, j}
    logic [2:0] flags_nxt;
    logic       dl_q;
    logic       hdr_ready;
    logic       ready_q;
    logic       region_set;
    logic [7:0] lo_chr;
    logic [7:0] hi_chr;
    logic [3:0] hrgn;

    function automatic logic [2:0] char_flags(input logic [7:0] c);
        return {c == "E", c == "U", c == "J"};
    endfunction

    assign lo_chr = rom.data[7:0];
    assign hi_chr = rom.data[15:8];
    assign hrgn   = lo_chr[3:0] - 4'd7;  // 'A'..'F' down to 10..15

    always_comb begin
        flags_nxt = flags;
        if (rom.download && !dl_q) flags_nxt = '0;  // new download
        if (rom.wr && rom.download) begin
            if (rom.addr == cart_pkg::HDR_REGION0) begin
                if (|char_flags(lo_chr)) flags_nxt = flags_nxt | char_flags(lo_chr);
                else if (lo_chr >= "0" && lo_chr <= "9") flags_nxt = {lo_chr[3], lo_chr[2], lo_chr[0]};
                else if (lo_chr >= "A" && lo_chr <= "F") flags_nxt = {hrgn[3], hrgn[2], hrgn[0]};
                flags_nxt = flags_nxt | char_flags(hi_chr);  // second char adds on top
            end
            if (rom.addr == cart_pkg::HDR_REGION1) flags_nxt = flags_nxt | char_flags(lo_chr);
        end
    end

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            flags      <= '0;
            dl_q       <= 1'b0;
            hdr_ready  <= 1'b0;
            ready_q    <= 1'b0;
            region_set <= 1'b0;
            region     <= cart_pkg::REGION_JP;
        end else begin
            flags   <= flags_nxt;
            dl_q    <= rom.download;
            ready_q <= hdr_ready;
            if (dl_q && !rom.download) hdr_ready <= 1'b0;
            if (rom.wr && rom.download && rom.addr == cart_pkg::HDR_END) hdr_ready <= 1'b1;

            // pick region once per header
            if (hdr_ready && !ready_q) begin
                region_set <= 1'b1;
                if (flags[1]) region <= cart_pkg::REGION_US;
                else if (flags[2]) region <= cart_pkg::REGION_EU;
                else if (flags[0]) region <= cart_pkg::REGION_JP;
                else region <= cart_pkg::REGION_US;
            end
            if (!hdr_ready && ready_q) region_set <= 1'b0;
        end
    end

    assign core_reset_n = ~region_set;  // console held in reset until download ends

    a_region_legal: assert property (
        @(posedge clk_74a) disable iff (!pll_core_locked)
        region != 2'd3
    );

endmodule

// File: rtl/cart_quirk_lookup.sv
// cart id capture from the ROM header
// title table match for quirks and lightgun settings

`timescale 1ns/1ps

module cart_quirk_lookup (
    input  logic             clk_74a,
    input  logic             pll_core_locked,
    rom_write_if.sink        rom,
    output cart_pkg::quirk_t quirks
);

    cart_pkg::cart_id_t             cart_id;
    cart_pkg::quirk_t               quirk_sel;
    logic [cart_pkg::TITLE_COUNT-1:0] hit;
    logic                           hdr_wr;

    assign hdr_wr = rom.wr && rom.download;

    // id text is byte swapped in the stream
    always_ff @(posedge clk_74a) begin
        if (hdr_wr) begin
            if (rom.addr == cart_pkg::HDR_ID0) cart_id[63:56] <= rom.data[15:8];
            if (rom.addr == cart_pkg::HDR_ID1) cart_id[55:40] <= {rom.data[7:0], rom.data[15:8]};
            if (rom.addr == cart_pkg::HDR_ID2) cart_id[39:24] <= {rom.data[7:0], rom.data[15:8]};
            if (rom.addr == cart_pkg::HDR_ID3) cart_id[23:8]  <= {rom.data[7:0], rom.data[15:8]};
            if (rom.addr == cart_pkg::HDR_ID4) cart_id[7:0]   <= rom.data[7:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // table match

    always_comb begin
        quirk_sel = cart_pkg::QUIRK_NONE;
        for (int i = 0; i < cart_pkg::TITLE_COUNT; i++) begin
            hit[i] = (cart_id == cart_pkg::TITLES[i].id);
            if (hit[i]) quirk_sel = cart_pkg::TITLES[i].quirk;
        end
    end

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) begin
            quirks <= cart_pkg::QUIRK_NONE;
        end else begin
            // flags drop during download, gun fields kept
            if (rom.download) begin
                quirks <= cart_pkg::quirk_t'{
                    gun_type:  quirks.gun_type,
                    gun_delay: quirks.gun_delay,
                    default:   '0
                };
            end
            if (hdr_wr && rom.addr == cart_pkg::HDR_ID_DONE) quirks <= quirk_sel;
        end
    end

    // titles in the table are distinct
    a_single_match: assert property (
        @(posedge clk_74a) disable iff (!pll_core_locked)
        (hdr_wr && rom.addr == cart_pkg::HDR_ID_DONE) |-> $onehot0(hit)
    );

endmodule

// File: rtl/pad_mapper.sv
// key synchronisers for four pads
// remap of pocket keys onto the console pad word, default or six-button layout

`timescale 1ns/1ps

module pad_mapper (
    input  logic                            clk_74a,
    input  logic                            pll_core_locked,
    input  logic [core_cfg_pkg::KEY_W-1:0]  keys [core_cfg_pkg::PAD_COUNT],
    input  logic [3:0]                      m30_map,
    output core_cfg_pkg::pad_word_t         pads [core_cfg_pkg::PAD_COUNT]
);

    logic [3:0] m30_q;  // retimed layout select

    always_ff @(posedge clk_74a or negedge pll_core_locked) begin
        if (!pll_core_locked) m30_q <= '0;
        else m30_q <= m30_map;
    end

    for (genvar p = 0; p < core_cfg_pkg::PAD_COUNT; p++) begin : g_pad
        logic [core_cfg_pkg::KEY_W-1:0] s1;
        logic [core_cfg_pkg::KEY_W-1:0] s2;
        logic [core_cfg_pkg::KEY_W-1:0] k;

        always_ff @(posedge clk_74a or negedge pll_core_locked) begin
            if (!pll_core_locked) begin
                s1 <= '0;
                s2 <= '0;
                k  <= '0;
            end else begin
                s1 <= keys[p];
                s2 <= s1;
                k  <= s2;
            end
        end

        // Z Y X mode start B C A then the dpad
        assign pads[p] = m30_q[p] ?
            {k[10], k[7], k[6], k[14], k[15], k[11], k[5], k[4], k[0], k[1], k[2], k[3]} :
            {k[9],  k[6], k[8], k[14], k[15], k[4],  k[5], k[7], k[0], k[1], k[2], k[3]};
    end

endmodule

// File: rtl/core_top.sv
// housekeeping top level
// settings bank, header region and quirk parsing, pad remap

`timescale 1ns/1ps

module core_top (
    input  logic                               clk_74a,
    input  logic                               pll_core_locked,
    input  logic [core_cfg_pkg::BRIDGE_W-1:0]  bridge_addr,
    input  logic                               bridge_wr,
    input  logic [core_cfg_pkg::BRIDGE_W-1:0]  bridge_wr_data,
    output logic [core_cfg_pkg::BRIDGE_W-1:0]  bridge_rd_data,
    input  logic                               rom_download,
    input  logic                               rom_wr,
    input  logic [cart_pkg::ROM_ADDR_W-1:0]    rom_addr,
    input  logic [cart_pkg::ROM_DATA_W-1:0]    rom_data,
    input  logic [core_cfg_pkg::KEY_W-1:0]     cont1_key,
    input  logic [core_cfg_pkg::KEY_W-1:0]     cont2_key,
    input  logic [core_cfg_pkg::KEY_W-1:0]     cont3_key,
    input  logic [core_cfg_pkg::KEY_W-1:0]     cont4_key,
    output core_cfg_pkg::core_cfg_t            core_cfg,
    output cart_pkg::region_e                  region,
    output logic                               core_reset_n,
    output cart_pkg::quirk_t                   quirks,
    output core_cfg_pkg::pad_word_t            joystick_0,
    output core_cfg_pkg::pad_word_t            joystick_1,
    output core_cfg_pkg::pad_word_t            joystick_2,
    output core_cfg_pkg::pad_word_t            joystick_3
);

    rom_write_if rom_bus ();

    logic [core_cfg_pkg::KEY_W-1:0] pad_keys  [core_cfg_pkg::PAD_COUNT];
    core_cfg_pkg::pad_word_t        pad_words [core_cfg_pkg::PAD_COUNT];

    // download stream in from the loader pins
    assign rom_bus.download = rom_download;
    assign rom_bus.wr       = rom_wr;
    assign rom_bus.addr     = rom_addr;
    assign rom_bus.data     = rom_data;

    assign pad_keys[0] = cont1_key;
    assign pad_keys[1] = cont2_key;
    assign pad_keys[2] = cont3_key;
    assign pad_keys[3] = cont4_key;

    assign joystick_0 = pad_words[0];
    assign joystick_1 = pad_words[1];
    assign joystick_2 = pad_words[2];
    assign joystick_3 = pad_words[3];

    ////////////////////////////////////////////////////////////
    // blocks

    core_settings u_settings (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .bridge_addr     (bridge_addr),
        .bridge_wr       (bridge_wr),
        .bridge_wr_data  (bridge_wr_data),
        .region          (region),
        .bridge_rd_data  (bridge_rd_data),
        .core_cfg        (core_cfg)
    );

    cart_region_detect u_region (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .rom             (rom_bus),
        .region          (region),
        .core_reset_n    (core_reset_n)
    );

    cart_quirk_lookup u_quirks (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .rom             (rom_bus),
        .quirks          (quirks)
    );

    pad_mapper u_pads (
        .clk_74a         (clk_74a),
        .pll_core_locked (pll_core_locked),
        .keys            (pad_keys),
        .m30_map         (core_cfg.m30_map),
        .pads            (pad_words)
    );

endmodule

// File: tb/tb_core_top.sv
// testbench for the housekeeping top level
// test lines from a data file, inputs driven on the falling edge
// typed compare tasks, per-test report and a watchdog

`timescale 1ns/1ps

module tb_core_top;

    logic                              clk_74a;
    logic                              pll_core_locked;
    logic [core_cfg_pkg::BRIDGE_W-1:0] bridge_addr;
    logic                              bridge_wr;
    logic [core_cfg_pkg::BRIDGE_W-1:0] bridge_wr_data;
    logic [core_cfg_pkg::BRIDGE_W-1:0] bridge_rd_data;
    logic                              rom_download;
    logic                              rom_wr;
    logic [cart_pkg::ROM_ADDR_W-1:0]   rom_addr;
    logic [cart_pkg::ROM_DATA_W-1:0]   rom_data;
    logic [core_cfg_pkg::KEY_W-1:0]    cont1_key, cont2_key, cont3_key, cont4_key;
    core_cfg_pkg::core_cfg_t           core_cfg;
    cart_pkg::region_e                 region;
    logic                              core_reset_n;
    cart_pkg::quirk_t                  quirks;
    core_cfg_pkg::pad_word_t           joystick_0, joystick_1, joystick_2, joystick_3;

    string lines [$];
    int    n_tests      = 0;
    int    errors       = 0;
    int    failed_tests = 0;
    bit    test_bad;

    core_top dut0 (.*);

    always #20 clk_74a = ~clk_74a;  // 40 ns period

    ////////////////////////////////////////////////////////////
    // compare tasks

    task automatic log_mismatch(input string name, input logic [63:0] exp, input logic [63:0] act);
        $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, act);
        errors++;
        test_bad = 1'b1;
    endtask

    task automatic check_cfg(input string name, input core_cfg_pkg::core_cfg_t exp,
                             input core_cfg_pkg::core_cfg_t act);
        if (act !== exp) log_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_region(input string name, input cart_pkg::region_e exp,
                                input cart_pkg::region_e act);
        if (act !== exp) log_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_quirks(input string name, input cart_pkg::quirk_t exp,
                                input cart_pkg::quirk_t act);
        if (act !== exp) log_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_pad(input string name, input core_cfg_pkg::pad_word_t exp,
                             input core_cfg_pkg::pad_word_t act);
        if (act !== exp) log_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp) log_mismatch(name, 64'(exp), 64'(act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) log_mismatch(name, 64'(exp), 64'(act));
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus helpers, all entered and left on a falling edge

    function automatic core_cfg_pkg::pad_word_t joystick_of(input logic [1:0] idx);
        case (idx)
            2'd0:    return joystick_0;
            2'd1:    return joystick_1;
            2'd2:    return joystick_2;
            default: return joystick_3;
        endcase
    endfunction

    task automatic set_keys(input logic [1:0] idx, input logic [15:0] keys);
        case (idx)
            2'd0:    cont1_key = keys;
            2'd1:    cont2_key = keys;
            2'd2:    cont3_key = keys;
            default: cont4_key = keys;
        endcase
    endtask

    task automatic rom_word(input logic [cart_pkg::ROM_ADDR_W-1:0] addr, input logic [15:0] data);
        rom_wr   = 1'b1;
        rom_addr = addr;
        rom_data = data;
        @(negedge clk_74a);
        rom_wr = 1'b0;
    endtask

    task automatic run_cfg(input logic [31:0] addr, input logic [31:0] data,
                           input core_cfg_pkg::core_cfg_t exp);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(negedge clk_74a);
        bridge_wr = 1'b0;
        check_cfg("core_cfg", exp, core_cfg);
    endtask

    task automatic run_header(input logic [15:0] w0, input logic [15:0] w1,
                              input cart_pkg::region_e exp);
        rom_download = 1'b1;
        @(negedge clk_74a);
        rom_word(cart_pkg::HDR_REGION0, w0);
        rom_word(cart_pkg::HDR_REGION1, w1);
        rom_word(cart_pkg::HDR_END, 16'h0000);
        check_bit("core_reset_n", 1'b1, core_reset_n);  // ready just up, no update yet
        @(negedge clk_74a);
        check_region("region", exp, region);
        check_bit("core_reset_n", 1'b0, core_reset_n);
        rom_download = 1'b0;
        @(negedge clk_74a);
        check_bit("core_reset_n", 1'b0, core_reset_n);
        @(negedge clk_74a);
        check_bit("core_reset_n", 1'b1, core_reset_n);
    endtask

    // id text goes in byte swapped, see the header layout
    task automatic run_quirk(input logic [63:0] id, input cart_pkg::quirk_t exp);
        rom_download = 1'b1;
        @(negedge clk_74a);
        check_word("quirks flags", 32'h0, 32'(quirks[17:9]));
        rom_word(cart_pkg::HDR_ID0, {id[63:56], 8'h20});
        rom_word(cart_pkg::HDR_ID1, {id[47:40], id[55:48]});
        rom_word(cart_pkg::HDR_ID2, {id[31:24], id[39:32]});
        rom_word(cart_pkg::HDR_ID3, {id[15:8], id[23:16]});
        rom_word(cart_pkg::HDR_ID4, {8'h20, id[7:0]});
        rom_word(cart_pkg::HDR_ID_DONE, 16'h0000);
        check_quirks("quirks", exp, quirks);
        rom_download = 1'b0;
        @(negedge clk_74a);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        int          fd;
        string       line;
        string       kind;
        logic [63:0] op1, op2, op3, op4, op5;

        clk_74a         = 1'b0;
        pll_core_locked = 1'b0;
        bridge_addr     = '0;
        bridge_wr       = 1'b0;
        bridge_wr_data  = '0;
        rom_download    = 1'b0;
        rom_wr          = 1'b0;
        rom_addr        = '0;
        rom_data        = '0;
        cont1_key       = '0;
        cont2_key       = '0;
        cont3_key       = '0;
        cont4_key       = '0;

        fd = $fopen("tb/core_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test file tb/core_tests.txt");
            errors++;
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") lines.push_back(line);
        end
        if (fd != 0) $fclose(fd);
        n_tests = lines.size();

        repeat (10) @(posedge clk_74a);
        @(negedge clk_74a);
        pll_core_locked = 1'b1;
        @(negedge clk_74a);

        foreach (lines[i]) begin
            test_bad = 1'b0;
            kind     = "";
            void'($sscanf(lines[i], "%s %h %h %h %h %h", kind, op1, op2, op3, op4, op5));
            if (kind == "reset") begin
                check_cfg("core_cfg", core_cfg_pkg::core_cfg_t'(op1[15:0]), core_cfg);
                check_region("region", cart_pkg::region_e'(op2[1:0]), region);
                check_quirks("quirks", cart_pkg::quirk_t'(op3[17:0]), quirks);
                check_bit("core_reset_n", op4[0], core_reset_n);
                check_pad("joystick_0", op5[11:0], joystick_0);
                check_pad("joystick_1", op5[11:0], joystick_1);
                check_pad("joystick_2", op5[11:0], joystick_2);
                check_pad("joystick_3", op5[11:0], joystick_3);
            end else if (kind == "cfg") begin
                run_cfg(op1[31:0], op2[31:0], core_cfg_pkg::core_cfg_t'(op3[15:0]));
            end else if (kind == "hdr") begin
                run_header(op1[15:0], op2[15:0], cart_pkg::region_e'(op3[1:0]));
            end else if (kind == "rd") begin
                bridge_addr = op1[31:0];
                @(negedge clk_74a);
                check_word("bridge_rd_data", op2[31:0], bridge_rd_data);
            end else if (kind == "quirk") begin
                run_quirk(op1, cart_pkg::quirk_t'(op2[17:0]));
            end else if (kind == "pad") begin
                set_keys(op1[1:0], op2[15:0]);
                repeat (3) @(negedge clk_74a);  // three sync stages
                check_pad($sformatf("joystick_%0d", op1[1:0]), op3[11:0], joystick_of(op1[1:0]));
            end else begin
                $display("test %0d has an unknown kind '%s'", i, kind);
                errors++;
                test_bad = 1'b1;
            end
            if (test_bad) begin
                failed_tests++;
                $display("test %0d %s failed", i, kind);
            end else begin
                $display("test %0d %s ok", i, kind);
            end
        end

        $display("tests %0d, failed %0d, errors %0d", n_tests, failed_tests, errors);
        if (errors == 0 && n_tests > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog, 40 cycles per test plus reset margin
    initial begin
        wait (n_tests > 0);
        repeat (n_tests * 40 + 100) @(posedge clk_74a);
        $display("timeout, the tests did not finish within %0d cycles", n_tests * 40 + 100);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: tb/core_tests.txt
# one test per line, operands and expected values in hex
# reset cfg region quirks rstn pad | cfg addr data cfg | hdr w0 w1 region | rd addr data
# quirk id quirks | pad index keys pad
reset 00F0 0 0002C 1 000
cfg 00C00000 3 C0F0
cfg 00F00000 2 E0F0
cfg 00A00000 1 E8F0
cfg 00000000 1 ECF0
cfg 00000010 1 EEF0
cfg 00000020 1 EFF0
cfg 00000030 0 EF70
cfg 00000040 0 EF30
cfg 00000050 0 EF10
cfg 00000060 0 EF00
cfg 00001234 FFFFFFFF EF00
hdr 2034 2020 1
hdr 2041 2020 2
rd 00E00000 2
hdr 204A 2020 0
hdr 204A 2045 2
hdr 2020 2020 1
rd 00E00000 1
rd 00000010 0
quirk 542D303831323736 2002C
quirk 4D4B2D3132313520 0802C
quirk 542D39353039362D 00134
quirk 542D313233343520 0002C
pad 0 0001 008
pad 1 8000 080
pad 2 0210 840
pad 3 01C0 610
pad 0 4C20 120
cfg 00000080 1 EF01
pad 0 4C20 960
cfg 00000090 1 EF03
pad 1 00D0 610
cfg 00000100 1 EF07
pad 2 0400 800
cfg 00000110 1 EF0F
pad 3 0900 040

// File: all.f
rtl/core_cfg_pkg.sv
rtl/cart_pkg.sv
rtl/rom_write_if.sv
rtl/core_settings.sv
rtl/cart_region_detect.sv
rtl/cart_quirk_lookup.sv
rtl/pad_mapper.sv
rtl/core_top.sv
tb/tb_core_top.sv

// File: Makefile
# Verilator build and run for the housekeeping core testbench

VERILATOR ?= verilator
TOP       ?= tb_core_top
FILELIST  ?= all.f
TESTS     ?= tb/core_tests.txt
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM) $(TESTS)
	./$(SIM) | tee $(LOG)
	@grep -qx "STATUS: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
